//--- rd_dma_top.f
rd_dma_pkg.sv
dma_regs.sv
rd_ctrl.sv
pkt_fifo.sv
rd_dma_top.sv
rd_dma_sva.sv
tb_rd_dma.sv

//--- run.sh
#!/bin/sh
# build and run the read DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_rd_dma -f rd_dma_top.f \
    --Mdir obj_dir -o sim_tb_rd_dma
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_rd_dma)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

//--- tb_rd_dma.sv
`timescale 1ns/1ps

module tb_rd_dma;
    import rd_dma_pkg::*;

    localparam int NUM_XFERS       = 20;
    localparam int CYCLES_PER_XFER = 2000;
    localparam int TIMEOUT_CYCLES  = NUM_XFERS * CYCLES_PER_XFER;
    localparam logic [31:0] MEM_KEY = 32'h5a5a0000;

    logic               clk = 1'b0;
    logic               reset;
    logic               reg_write;
    logic [1:0]         reg_addr;
    logic [DATA_W-1:0]  reg_wdata;
    logic [DATA_W-1:0]  reg_rdata;
    logic [DATA_W-1:0]  address;
    logic               read;
    logic [BURST_W-1:0] burstcount;
    logic [DATA_W-1:0]  readdata;
    logic               readdatavalid;
    logic               waitrequest;
    logic [DATA_W-1:0]  fifo_rdata;
    logic               fifo_empty;
    logic               fifo_rd;

    logic [31:0] lfsr_state = 32'hb9cf0ab3;
    logic [31:0] beat_q [$];
    logic [31:0] rx_q [$];
    logic [31:0] exp_addr;
    int          exp_left;
    int          cmd_count;
    int          cur_xfer;
    logic        slow_drain;
    int          checks;
    int          errors;

    rd_dma_top rd_dma_top_i (
        .clk           (clk),
        .reset         (reset),
        .reg_write     (reg_write),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata),
        .address       (address),
        .read          (read),
        .burstcount    (burstcount),
        .readdata      (readdata),
        .readdatavalid (readdatavalid),
        .waitrequest   (waitrequest),
        .fifo_rdata    (fifo_rdata),
        .fifo_empty    (fifo_empty),
        .fifo_rd       (fifo_rd)
    );

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
        reg_write = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_write = 1'b0;
        reg_addr  = REG_STATUS;
    endtask

    task automatic run_transfer(input int idx, input logic [31:0] begin_addr, input int len);
        logic [31:0] status;
        int          polls;
        int          i;
        cur_xfer  = idx;
        exp_addr  = begin_addr;
        exp_left  = len;
        cmd_count = 0;
        write_reg(REG_BEGIN, begin_addr);
        write_reg(REG_END, begin_addr + 32'(len) * 4);
        write_reg(REG_CONTROL, 32'(1) << CTRL_START);
        polls = 0;
        do begin
            @(negedge clk);
            status = reg_rdata;
            polls++;
            // busy holds from the start until done is set
            if (!status[ST_DONE]) begin
                check_value($sformatf("xfer %0d busy before done", idx), 32'(1),
                            32'(status[ST_BUSY]));
            end
            // a second start while busy must be ignored
            if (polls == 3 && status[ST_BUSY]) begin
                write_reg(REG_CONTROL, 32'(1) << CTRL_START);
            end
        end while (!status[ST_DONE]);
        check_value($sformatf("xfer %0d busy at done", idx), 32'(0), 32'(status[ST_BUSY]));
        while (!fifo_empty) begin
            @(negedge clk);
        end
        check_value($sformatf("xfer %0d words left", idx), 32'(0), 32'(exp_left));
        check_value($sformatf("xfer %0d commands", idx), 32'((len + 15) / 16),
                    32'(cmd_count));
        check_value($sformatf("xfer %0d beats pending", idx), 32'(0), 32'(beat_q.size()));
        check_value($sformatf("xfer %0d word count", idx), 32'(len), 32'(rx_q.size()));
        for (i = 0; i < len && i < rx_q.size(); i++) begin
            check_value($sformatf("xfer %0d word %0d", idx, i),
                        (begin_addr + 32'(i) * 4) ^ MEM_KEY, rx_q[i]);
        end
        rx_q.delete();
    endtask

    initial begin : clock_gen
        forever #20 clk = ~clk;
    end

    // avalon slave, beats are handled before a new command is taken
    initial begin : memory_model
        int i;
        int exp_bc;
        readdata      = '0;
        readdatavalid = 1'b0;
        waitrequest   = 1'b0;
        forever begin
            @(negedge clk);
            if (beat_q.size() != 0 && rand_bits(2) != 0) begin
                readdatavalid = 1'b1;
                readdata      = beat_q.pop_front() ^ MEM_KEY;
            end
            else begin
                readdatavalid = 1'b0;
                readdata      = '0;
            end
            waitrequest = (rand_bits(2) == 0);
            if (reset && read && !waitrequest) begin
                exp_bc = (exp_left < BURST_MAX) ? exp_left : BURST_MAX;
                check_value($sformatf("xfer %0d burst address", cur_xfer), exp_addr, address);
                check_value($sformatf("xfer %0d burstcount", cur_xfer), 32'(exp_bc),
                            32'(burstcount));
                for (i = 0; i < int'(burstcount); i++) begin
                    beat_q.push_back(address + 32'(i) * 4);
                end
                exp_addr  = exp_addr + 32'(exp_bc) * 4;
                exp_left  = exp_left - exp_bc;
                cmd_count++;
            end
        end
    end

    // the slow rate lets almost_full rise on long packets
    initial begin : drain
        logic pop;
        fifo_rd = 1'b0;
        forever begin
            @(negedge clk);
            if (slow_drain) begin
                pop = (rand_bits(3) == 0);
            end
            else begin
                pop = (rand_bits(1) != 0);
            end
            fifo_rd = pop && !fifo_empty && reset;
            if (fifo_rd) begin
                rx_q.push_back(fifo_rdata);
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: transfers did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        int          t;
        int          len;
        logic [31:0] begin_addr;
        checks     = 0;
        errors     = 0;
        slow_drain = 1'b1;
        reset      = 1'b0;
        reg_write  = 1'b0;
        reg_addr   = REG_STATUS;
        reg_wdata  = '0;
        repeat (10) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        check_value("reset read", 32'(0), 32'(read));
        check_value("reset fifo_empty", 32'(1), 32'(fifo_empty));
        check_value("reset status", 32'(0), reg_rdata);

        // begin equal to end
        run_transfer(0, 32'h0000_2000, 0);
        for (t = 1; t <= NUM_XFERS; t++) begin
            len = int'(rand_bits(7) % 71);
            // every fifth packet is long enough to hit almost_full
            if (t % 5 == 0) begin
                len = 49 + int'(rand_bits(5) % 22);
            end
            begin_addr = 32'h0001_0000 + (rand_bits(14) << 2);
            slow_drain = t[0];
            run_transfer(t, begin_addr, len);
        end

        repeat (20) @(negedge clk);
        check_value("idle read", 32'(0), 32'(read));
        check_value("idle fifo_empty", 32'(1), 32'(fifo_empty));
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- rd_dma_sva.sv
`timescale 1ns/1ps

module rd_dma_sva (
    input logic                           clk,
    input logic                           reset,
    input logic                           read,
    input logic                           waitrequest,
    input logic [rd_dma_pkg::DATA_W-1:0]  address,
    input logic [rd_dma_pkg::BURST_W-1:0] burstcount,
    input logic                           almost_full,
    input logic                           rd_ctrl_rdy
);
    import rd_dma_pkg::*;

    // command held while the slave stalls
    hold_cmd: assert property (@(posedge clk) disable iff (!reset)
        read && waitrequest |=> read && $stable(address) && $stable(burstcount))
        else $error("read command changed while waitrequest was high");

    burst_range: assert property (@(posedge clk) disable iff (!reset)
        read |-> (burstcount >= BURST_W'(1)) && (burstcount <= BURST_W'(BURST_MAX)))
        else $error("burstcount out of range while read is high");

    // read rises on the edge that saw almost_full low
    no_start_when_full: assert property (@(posedge clk) disable iff (!reset)
        $rose(read) |-> !$past(almost_full))
        else $error("burst started while almost_full was high");

    rdy_one_cycle: assert property (@(posedge clk) disable iff (!reset)
        rd_ctrl_rdy |=> !rd_ctrl_rdy)
        else $error("rd_ctrl_rdy lasted more than one cycle");

endmodule

bind rd_ctrl rd_dma_sva rd_dma_sva_i (
    .clk         (clk),
    .reset       (reset),
    .read        (read),
    .waitrequest (waitrequest),
    .address     (address),
    .burstcount  (burstcount),
    .almost_full (almost_full),
    .rd_ctrl_rdy (rd_ctrl_rdy)
);

//--- rd_dma_top.sv
`timescale 1ns/1ps

module rd_dma_top (
    input  logic                           clk,
    input  logic                           reset,
    // host register port
    input  logic                           reg_write,
    input  logic [1:0]                     reg_addr,
    input  logic [rd_dma_pkg::DATA_W-1:0]  reg_wdata,
    output logic [rd_dma_pkg::DATA_W-1:0]  reg_rdata,
    // avalon-mm read master
    output logic [rd_dma_pkg::DATA_W-1:0]  address,
    output logic                           read,
    output logic [rd_dma_pkg::BURST_W-1:0] burstcount,
    input  logic [rd_dma_pkg::DATA_W-1:0]  readdata,
    input  logic                           readdatavalid,
    input  logic                           waitrequest,
    // packet fifo read side
    output logic [rd_dma_pkg::DATA_W-1:0]  fifo_rdata,
    output logic                           fifo_empty,
    input  logic                           fifo_rd
);
    import rd_dma_pkg::*;

    logic              rd_ctrl;
    logic              rd_ctrl_rdy;
    logic [DATA_W-1:0] pkt_begin;
    logic [DATA_W-1:0] pkt_end;
    logic [DATA_W-1:0] fifo_in;
    logic              wr_to_fifo;
    logic              almost_full;

    dma_regs dma_regs_i (
        .clk         (clk),
        .reset       (reset),
        .reg_write   (reg_write),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .rd_ctrl_rdy (rd_ctrl_rdy),
        .reg_rdata   (reg_rdata),
        .rd_ctrl     (rd_ctrl),
        .pkt_begin   (pkt_begin),
        .pkt_end     (pkt_end)
    );

    rd_ctrl rd_ctrl_i (
        .clk           (clk),
        .reset         (reset),
        .rd_ctrl       (rd_ctrl),
        .almost_full   (almost_full),
        .pkt_begin     (pkt_begin),
        .pkt_end       (pkt_end),
        .readdata      (readdata),
        .readdatavalid (readdatavalid),
        .waitrequest   (waitrequest),
        .fifo_in       (fifo_in),
        .wr_to_fifo    (wr_to_fifo),
        .rd_ctrl_rdy   (rd_ctrl_rdy),
        .address       (address),
        .read          (read),
        .burstcount    (burstcount)
    );

    pkt_fifo pkt_fifo_i (
        .clk         (clk),
        .reset       (reset),
        .wr_to_fifo  (wr_to_fifo),
        .fifo_in     (fifo_in),
        .fifo_rd     (fifo_rd),
        .fifo_rdata  (fifo_rdata),
        .fifo_empty  (fifo_empty),
        .almost_full (almost_full)
    );

endmodule

//--- pkt_fifo.sv
`timescale 1ns/1ps

module pkt_fifo (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wr_to_fifo,
    input  logic [rd_dma_pkg::DATA_W-1:0] fifo_in,
    input  logic                          fifo_rd,
    output logic [rd_dma_pkg::DATA_W-1:0] fifo_rdata,
    output logic                          fifo_empty,
    output logic                          almost_full
);
    import rd_dma_pkg::*;

    logic [DATA_W-1:0]  mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               do_wr;
    logic               do_rd;

    // writes into a full fifo are dropped
    assign do_wr = wr_to_fifo && (count != (FIFO_AW+1)'(FIFO_DEPTH));
    assign do_rd = fifo_rd && (count != '0);

    // show-ahead, head word is always on the output
    assign fifo_rdata  = mem[rd_ptr];
    assign fifo_empty  = (count == '0);
    assign almost_full = (count >= (FIFO_AW+1)'(AF_LEVEL));

    always_ff @(posedge clk) begin : storage
        if (do_wr) begin
            mem[wr_ptr] <= fifo_in;
        end
    end

    always_ff @(posedge clk) begin : pointers
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + FIFO_AW'(1);
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + FIFO_AW'(1);
            end
            // pointers wrap naturally at FIFO_DEPTH
            case ({do_wr, do_rd})
                2'b10:   count <= count + (FIFO_AW+1)'(1);
                2'b01:   count <= count - (FIFO_AW+1)'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rd_ctrl.sv
`timescale 1ns/1ps

module rd_ctrl (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           rd_ctrl,
    input  logic                           almost_full,
    input  logic [rd_dma_pkg::DATA_W-1:0]  pkt_begin,
    input  logic [rd_dma_pkg::DATA_W-1:0]  pkt_end,
    input  logic [rd_dma_pkg::DATA_W-1:0]  readdata,
    input  logic                           readdatavalid,
    input  logic                           waitrequest,
    output logic [rd_dma_pkg::DATA_W-1:0]  fifo_in,
    output logic                           wr_to_fifo,
    output logic                           rd_ctrl_rdy,
    output logic [rd_dma_pkg::DATA_W-1:0]  address,
    output logic                           read,
    output logic [rd_dma_pkg::BURST_W-1:0] burstcount
);
    import rd_dma_pkg::*;

    enum logic [1:0] { IDLE, RUN, DONE } state, state_next;

    logic [DATA_W-1:0]  pkt_words;
    logic [DATA_W-1:0]  words_left;
    logic [DATA_W-1:0]  next_addr;
    logic [BURST_W-1:0] beats_left;
    logic [BURST_W-1:0] burst_size;
    logic               burst_start;
    logic               last_beat;

    // packet length in words, bounds are word aligned
    assign pkt_words = (pkt_end - pkt_begin) >> 2;

    // words_left counts words not yet requested, so it is already
    // zero while the final burst is still returning beats
    assign burst_size = (words_left < DATA_W'(BURST_MAX)) ?
                        words_left[BURST_W-1:0] : BURST_W'(BURST_MAX);

    // next burst only once the previous one has fully returned
    assign burst_start = (state == RUN) && !read && (beats_left == '0) &&
                         (words_left != '0) && !almost_full;

    assign last_beat = (state == RUN) && readdatavalid &&
                       (beats_left == BURST_W'(1)) && (words_left == '0);

    // DONE lasts exactly one cycle
    assign rd_ctrl_rdy = (state == DONE);

    always_ff @(posedge clk) begin : states
        if (!reset) begin
            state <= IDLE;
        end
        else begin
            state <= state_next;
        end
    end

    always_comb begin : fsm
        state_next = state;
        case (state)
            IDLE: begin
                if (rd_ctrl) begin
                    // zero length skips straight to completion
                    state_next = (pkt_words == '0) ? DONE : RUN;
                end
            end
            RUN: begin
                if (last_beat) begin
                    state_next = DONE;
                end
            end
            DONE: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin : burst_plan
        if (state == IDLE && rd_ctrl) begin
            next_addr  <= pkt_begin;
            words_left <= pkt_words;
        end
        else if (burst_start) begin
            next_addr  <= next_addr + (DATA_W'(burst_size) << 2);
            words_left <= words_left - DATA_W'(burst_size);
        end
    end

    always_ff @(posedge clk) begin : avalon_mm_ctrl
        if (!reset) begin
            read       <= 1'b0;
            beats_left <= '0;
        end
        else begin
            // hold read until the slave accepts the command
            if (burst_start) begin
                read <= 1'b1;
            end
            else if (!waitrequest) begin
                read <= 1'b0;
            end

            if (burst_start) begin
                beats_left <= burst_size;
            end
            else if (readdatavalid && beats_left != '0) begin
                beats_left <= beats_left - BURST_W'(1);
            end
        end
    end

    // command fields stay put until the next burst
    always_ff @(posedge clk) begin : avalon_cmd
        if (burst_start) begin
            address    <= next_addr;
            burstcount <= burst_size;
        end
    end

    // every returned beat goes to the fifo one cycle later
    always_ff @(posedge clk) begin : fifo_ctrl
        fifo_in <= readdata;
        if (!reset) begin
            wr_to_fifo <= 1'b0;
        end
        else begin
            wr_to_fifo <= readdatavalid && (state == RUN);
        end
    end

endmodule

//--- dma_regs.sv
`timescale 1ns/1ps

module dma_regs (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          reg_write,
    input  logic [1:0]                    reg_addr,
    input  logic [rd_dma_pkg::DATA_W-1:0] reg_wdata,
    input  logic                          rd_ctrl_rdy,
    output logic [rd_dma_pkg::DATA_W-1:0] reg_rdata,
    output logic                          rd_ctrl,
    output logic [rd_dma_pkg::DATA_W-1:0] pkt_begin,
    output logic [rd_dma_pkg::DATA_W-1:0] pkt_end
);
    import rd_dma_pkg::*;

    logic busy;
    logic done;
    logic start_req;

    // a start is only taken while no transfer runs
    assign start_req = reg_write && (reg_addr == REG_CONTROL) &&
                       reg_wdata[CTRL_START] && !busy;

    // packet bounds, sampled by the controller on the start pulse
    always_ff @(posedge clk) begin : addr_regs
        if (reg_write && reg_addr == REG_BEGIN) begin
            pkt_begin <= reg_wdata;
        end
        if (reg_write && reg_addr == REG_END) begin
            pkt_end <= reg_wdata;
        end
    end

    always_ff @(posedge clk) begin : status_regs
        if (!reset) begin
            rd_ctrl <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
        end
        else begin
            rd_ctrl <= 1'b0;
            if (start_req) begin
                rd_ctrl <= 1'b1;
                busy    <= 1'b1;
                done    <= 1'b0;
            end
            else if (rd_ctrl_rdy) begin
                // done stays set until the next start
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // register read mux, control reads back as zero
    always_comb begin : read_mux
        reg_rdata = '0;
        case (reg_addr)
            REG_BEGIN: begin
                reg_rdata = pkt_begin;
            end
            REG_END: begin
                reg_rdata = pkt_end;
            end
            REG_STATUS: begin
                reg_rdata[ST_BUSY] = busy;
                reg_rdata[ST_DONE] = done;
            end
            default: begin
                reg_rdata = '0;
            end
        endcase
    end

endmodule

//--- rd_dma_pkg.sv
package rd_dma_pkg;

    // data and byte address width
    localparam int DATA_W = 32;

    // avalon burstcount width and the largest burst issued
    localparam int BURST_W   = 16;
    localparam int BURST_MAX = 16;

    // packet fifo geometry
    localparam int FIFO_DEPTH = 64;
    localparam int FIFO_AW    = 6;
    // leaves room for one full burst above the threshold
    localparam int AF_LEVEL   = 48;

    // host register map
    localparam logic [1:0] REG_CONTROL = 2'd0;
    localparam logic [1:0] REG_BEGIN   = 2'd1;
    localparam logic [1:0] REG_END     = 2'd2;
    localparam logic [1:0] REG_STATUS  = 2'd3;

    // status bits
    localparam int ST_BUSY = 0;
    localparam int ST_DONE = 1;

    // start bit in the control word
    localparam int CTRL_START = 0;

endpackage
